/* port_scheduler.f */
+incdir+verilog
verilog/sched_pkg.sv
verilog/sched_axil_regs.sv
verilog/req_tracker.sv
verilog/priority_control.sv
verilog/port_scheduler_top.sv
tb/port_scheduler_asserts.sv
tb/port_scheduler_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the port scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module port_scheduler_tb \
    -f port_scheduler.f

./obj_dir/Vport_scheduler_tb 2>&1 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail, see sim.log"
    exit 1
fi

/* tb/port_scheduler_tb.sv */
// port scheduler testbench with AXI tasks, random traffic and a cycle model of tracker and arbiter
`timescale 1ns/1ps
`include "sched_cfg.svh"

module port_scheduler_tb import sched_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 8000;  // four 1500-cycle phases plus margin
    localparam int NP = `SCHED_PORTS;

    logic       clk;
    logic       rst_n;
    axil_addr_t s_axil_awaddr;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    axil_data_t s_axil_wdata;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    logic [1:0] s_axil_bresp;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    axil_addr_t s_axil_araddr;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    axil_data_t s_axil_rdata;
    logic [1:0] s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;
    port_mask_t enq;
    port_idx_t  grant;
    logic       grant_vld;
    logic       grant_rdy;

    int seed = 51188;
    int enq_mode;  // 0 idle, 1 sparse, 2 all ports, 3 bursts
    int rdy_lvl;   // grant_rdy high in rdy_lvl of 4 cycles
    int cycles;
    int grant_errs;
    int mask_errs;
    int data_errs;
    int flag_errs;

    // model state
    int         m_cnt [NP];
    logic       m_en;
    logic       m_scheme;
    pri_vec_t   m_pri;
    port_idx_t  m_ptr;
    int         m_credit;
    logic       m_vld;
    port_idx_t  m_grant;
    port_mask_t exp_status;  // pending mask at the last AR transfer

    axil_data_t rd;
    pri_vec_t   pv;

    port_scheduler_top i_dut (.*);

    always #10 clk = ~clk;

    task automatic check_grant(input port_idx_t got, input port_idx_t exp, input string name);
        if (got !== exp) begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            grant_errs++;
        end
    endtask

    task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string name);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            mask_errs++;
        end
    endtask

    task automatic check_data(input axil_data_t got, input axil_data_t exp, input string name);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            flag_errs++;
        end
    endtask

    task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
        @(posedge clk);
        s_axil_awaddr  <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wvalid  <= 1'b1;
        s_axil_bready  <= 1'b1;
        do @(posedge clk); while (!(s_axil_awready && s_axil_wready));
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        do @(posedge clk); while (!s_axil_bvalid);
        check_data(axil_data_t'(s_axil_bresp), axil_data_t'(0), "s_axil_bresp");
        s_axil_bready <= 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr, output axil_data_t data);
        @(posedge clk);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        s_axil_rready  <= 1'b1;
        do @(posedge clk); while (!s_axil_arready);
        s_axil_arvalid <= 1'b0;
        do @(posedge clk); while (!s_axil_rvalid);
        data = s_axil_rdata;
        check_data(axil_data_t'(s_axil_rresp), axil_data_t'(0), "s_axil_rresp");
        s_axil_rready <= 1'b0;
    endtask

    // highest level wins and the strict compare keeps the lowest index on ties
    function automatic port_idx_t fixed_winner(input port_mask_t r, input pri_vec_t p);
        port_idx_t w;
        int        best;
        w = '0;
        best = -1;
        for (int i = 0; i < NP; i++) begin
            if (r[i] && int'(p[3*i +: 3]) > best) begin
                best = int'(p[3*i +: 3]);
                w = port_idx_t'(i);
            end
        end
        return w;
    endfunction

    function automatic port_idx_t next_after(input port_mask_t r, input port_idx_t ptr);
        port_idx_t w;
        logic      found;
        w = ptr;
        found = 1'b0;
        for (int k = 1; k <= NP; k++) begin
            if (!found && r[(int'(ptr) + k) % NP]) begin
                w = port_idx_t'((int'(ptr) + k) % NP);
                found = 1'b1;
            end
        end
        return w;
    endfunction

    // random traffic and downstream back-pressure
    always @(posedge clk) begin
        if (rst_n) begin
            enq       <= '0;
            grant_rdy <= 1'b0;
        end else begin
            case (enq_mode)
                0: enq <= '0;
                1: enq <= (($random(seed) & 3) == 0) ? port_mask_t'(1 << ($random(seed) & 7)) : '0;
                2: enq <= '1;
                default: enq <= (($random(seed) & 15) == 0) ? '1
                                : port_mask_t'($random(seed) & $random(seed));
            endcase
            grant_rdy <= (($random(seed) & 3) < rdy_lvl);
        end
    end

    // cycle model that sees the same pre-edge values as the DUT
    always @(posedge clk) begin : model
        port_mask_t r;
        port_mask_t dq;
        logic       acc;
        logic       dec;
        int         w;
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end else if (rst_n) begin
            for (int i = 0; i < NP; i++)
                m_cnt[i] = 0;
            m_en = 1'b0;
            m_scheme = 1'b0;
            m_pri = '0;
            m_ptr = '0;
            m_credit = 0;
            m_vld = 1'b0;
            m_grant = '0;
        end else begin
            check_flag(grant_vld, m_vld, "grant_vld");
            if (m_vld)
                check_grant(grant, m_grant, "grant");  // also catches a moving grant
            for (int i = 0; i < NP; i++)
                r[i] = (m_cnt[i] != 0);
            if (s_axil_arvalid && s_axil_arready)
                exp_status = r;
            acc = m_vld && grant_rdy;
            dq  = acc ? port_mask_t'(1 << m_grant) : '0;
            dec = !m_vld && m_en && (r != '0);
            w   = int'(m_pri[3*m_ptr +: 3]);
            if (dec) begin
                if (!m_scheme) begin
                    m_grant = fixed_winner(r, m_pri);
                end else if (r[m_ptr] && m_credit <= w) begin
                    m_grant = m_ptr;  // another turn for the current port
                    m_credit++;
                end else begin
                    m_grant = next_after(r, m_ptr);
                    m_ptr = m_grant;
                    m_credit = 1;
                end
            end else if (!m_en) begin
                m_ptr = '0;
                m_credit = 0;
            end
            for (int i = 0; i < NP; i++) begin
                if (enq[i] && !dq[i] && m_cnt[i] < `SCHED_PEND_MAX)
                    m_cnt[i]++;
                else if (!enq[i] && dq[i] && m_cnt[i] > 0)
                    m_cnt[i]--;
            end
            if (acc)
                m_vld = 1'b0;
            else if (dec)
                m_vld = 1'b1;
            // register writes take effect from the next edge
            if (s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready) begin
                if (s_axil_awaddr == 4'h0) begin
                    m_en = s_axil_wdata[0];
                    m_scheme = s_axil_wdata[1];
                end else if (s_axil_awaddr == 4'h4) begin
                    m_pri = s_axil_wdata[23:0];
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b1;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        enq = '0;
        grant_rdy = 1'b0;
        enq_mode = 0;
        rdy_lvl = 4;
        repeat (10) @(posedge clk);
        rst_n <= 1'b0;

        // reset values and readback
        repeat (3) @(posedge clk);
        check_flag(grant_vld, 1'b0, "grant_vld");
        axi_read(4'h0, rd);
        check_data(rd, axil_data_t'(0), "ctrl");
        axi_read(4'h4, rd);
        check_data(rd, axil_data_t'(0), "priorities");
        axi_write(4'h0, 32'h2);
        axi_read(4'h0, rd);
        check_data(rd, 32'h2, "ctrl");
        pv = pri_vec_t'($random(seed));
        axi_write(4'h4, axil_data_t'(pv));
        axi_read(4'h4, rd);
        check_data(rd, axil_data_t'(pv), "priorities");
        axi_write(4'h8, 32'hffff_ffff);  // status is read-only
        axi_read(4'h0, rd);
        check_data(rd, 32'h2, "ctrl");

        // fixed priority with sparse traffic, so the status mask varies
        axi_write(4'h4, axil_data_t'(pri_vec_t'($random(seed))));
        axi_write(4'h0, 32'h1);
        enq_mode <= 1;
        rdy_lvl  <= 3;
        for (int i = 0; i < 25; i++) begin
            repeat (60) @(posedge clk);
            axi_read(4'h8, rd);
            check_mask(port_mask_t'(rd), exp_status, "status");
        end

        // WRR with every port pending first
        axi_write(4'h4, axil_data_t'(pri_vec_t'($random(seed))));
        axi_write(4'h0, 32'h3);
        enq_mode <= 2;
        rdy_lvl  <= 4;
        repeat (750) @(posedge clk);
        enq_mode <= 1;
        repeat (750) @(posedge clk);

        // back-pressure with bursts into saturation
        enq_mode <= 3;
        rdy_lvl  <= 1;
        for (int i = 0; i < 20; i++) begin
            repeat (60) @(posedge clk);
            axi_read(4'h8, rd);
            check_mask(port_mask_t'(rd), exp_status, "status");
        end

        // disable and then WRR again from port 0
        enq_mode <= 1;
        rdy_lvl  <= 4;
        axi_write(4'h0, 32'h2);
        repeat (200) @(posedge clk);
        axi_write(4'h0, 32'h3);
        repeat (300) @(posedge clk);
        enq_mode <= 0;
        repeat (20) @(posedge clk);

        $display("error counts: grant %0d, mask %0d, data %0d, flag %0d",
                 grant_errs, mask_errs, data_errs, flag_errs);
        if (grant_errs + mask_errs + data_errs + flag_errs == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* tb/port_scheduler_asserts.sv */
// grant handshake and post-reset checks on the arbiter, bound into priority_control
`timescale 1ns/1ps

module port_scheduler_asserts import sched_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input port_idx_t  grant,
    input logic       grant_vld,
    input logic       grant_rdy,
    input port_mask_t deq
);

    // stalled grant keeps its port
    a_grant_hold: assert property (@(posedge clk) disable iff (rst_n)
        grant_vld && !grant_rdy |=> grant_vld && $stable(grant))
        else $error("grant changed or dropped while stalled");

    a_deq_onehot: assert property (@(posedge clk) disable iff (rst_n) $onehot0(deq))
        else $error("deq has more than one bit set");

    a_deq_accept: assert property (@(posedge clk) disable iff (rst_n)
        deq == ((grant_vld && grant_rdy) ? port_mask_t'(1 << grant) : port_mask_t'(0)))
        else $error("deq does not match the accepted grant");

    a_vld_bubble: assert property (@(posedge clk) disable iff (rst_n)
        grant_vld && grant_rdy |=> !grant_vld)
        else $error("grant_vld stayed high after acceptance");

    // quiet for two edges after reset release
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n && ($past(rst_n) || $past(rst_n, 2)) |-> !grant_vld)
        else $error("grant_vld high right after reset");

endmodule

bind priority_control port_scheduler_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .grant_vld (grant_vld),
    .grant_rdy (grant_rdy),
    .deq       (deq)
);

/* verilog/port_scheduler_top.sv */
// output-port scheduler top joining the register block, request tracker and arbiter
`timescale 1ns/1ps

module port_scheduler_top import sched_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  axil_addr_t s_axil_awaddr,
    input  logic       s_axil_awvalid,
    output logic       s_axil_awready,
    input  axil_data_t s_axil_wdata,
    input  logic       s_axil_wvalid,
    output logic       s_axil_wready,
    output logic [1:0] s_axil_bresp,
    output logic       s_axil_bvalid,
    input  logic       s_axil_bready,
    input  axil_addr_t s_axil_araddr,
    input  logic       s_axil_arvalid,
    output logic       s_axil_arready,
    output axil_data_t s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    output logic       s_axil_rvalid,
    input  logic       s_axil_rready,
    input  port_mask_t enq,
    output port_idx_t  grant,
    output logic       grant_vld,
    input  logic       grant_rdy
);

    logic       arb_en;
    logic       scheme;
    pri_vec_t   priorities;
    port_mask_t req;
    port_mask_t pending;
    port_mask_t deq;

    sched_axil_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .pending        (pending),
        .arb_en         (arb_en),
        .scheme         (scheme),
        .priorities     (priorities)
    );

    req_tracker u_tracker (
        .clk     (clk),
        .rst_n   (rst_n),
        .enq     (enq),
        .deq     (deq),
        .req     (req),
        .pending (pending)
    );

    priority_control u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .priorities (priorities),
        .scheme     (scheme),
        .arb_en     (arb_en),
        .grant      (grant),
        .grant_vld  (grant_vld),
        .grant_rdy  (grant_rdy),
        .deq        (deq)
    );

endmodule

/* verilog/priority_control.sv */
// fixed priority and WRR arbiter with a registered grant on a valid/ready pair
`timescale 1ns/1ps
`include "sched_cfg.svh"

module priority_control import sched_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  port_mask_t req,
    input  pri_vec_t   priorities,
    input  logic       scheme,
    input  logic       arb_en,
    output port_idx_t  grant,
    output logic       grant_vld,
    input  logic       grant_rdy,
    output port_mask_t deq
);

    localparam int NP   = `SCHED_PORTS;
    localparam int PW   = $bits(pri_t);
    localparam int CR_W = PW + 1;  // credit can reach weight plus one

    pri_t            pri_fld [NP];
    port_idx_t       fix_pick;
    pri_t            fix_best;
    port_idx_t       wrr_ptr;
    logic [CR_W-1:0] wrr_credit;
    port_idx_t       wrr_next;
    logic            wrr_stay;
    port_idx_t       pick;
    logic            decide;
    logic            accept;

    always_comb begin
        for (int i = 0; i < NP; i++)
            pri_fld[i] = priorities[i*PW +: PW];
    end

    // descending scan with >= so equal levels fall to the lower index
    always_comb begin
        fix_pick = '0;
        fix_best = '0;
        for (int i = NP - 1; i >= 0; i--) begin
            if (req[i] && (pri_fld[i] >= fix_best)) begin
                fix_pick = port_idx_t'(i);
                fix_best = pri_fld[i];
            end
        end
    end

    // first requester after the pointer, wrapping back onto the pointer last
    always_comb begin
        wrr_next = wrr_ptr;
        for (int k = NP; k >= 1; k--) begin
            if (req[(int'(wrr_ptr) + k) % NP])
                wrr_next = port_idx_t'((int'(wrr_ptr) + k) % NP);
        end
    end

    assign wrr_stay = req[wrr_ptr] && (wrr_credit <= CR_W'(pri_fld[wrr_ptr]));

    assign pick   = scheme ? (wrr_stay ? wrr_ptr : wrr_next) : fix_pick;
    assign decide = !grant_vld && arb_en && (|req);
    assign accept = grant_vld && grant_rdy;

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            wrr_ptr    <= '0;
            wrr_credit <= '0;
        end else if (!arb_en) begin
            wrr_ptr    <= '0;  // restart from port 0 on re-enable
            wrr_credit <= '0;
        end else if (decide && scheme) begin
            if (wrr_stay) begin
                wrr_credit <= wrr_credit + 1'b1;
            end else begin
                wrr_ptr    <= wrr_next;
                wrr_credit <= CR_W'(1);
            end
        end
    end

    // a bubble follows every acceptance so the decremented count is seen
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n)
            grant_vld <= 1'b0;
        else if (accept)
            grant_vld <= 1'b0;
        else if (decide)
            grant_vld <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (decide)
            grant <= pick;  // held under back-pressure
    end

    always_comb begin
        deq = '0;
        if (accept)
            deq[grant] = 1'b1;
    end

endmodule

/* verilog/req_tracker.sv */
// per-port saturating pending counters turning enqueue pulses into request lines
`timescale 1ns/1ps
`include "sched_cfg.svh"

module req_tracker import sched_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  port_mask_t enq,
    input  port_mask_t deq,
    output port_mask_t req,
    output port_mask_t pending
);

    localparam pend_cnt_t PEND_MAX = pend_cnt_t'(`SCHED_PEND_MAX);

    pend_cnt_t cnt [`SCHED_PORTS];

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            for (int i = 0; i < `SCHED_PORTS; i++)
                cnt[i] <= '0;
        end else begin
            for (int i = 0; i < `SCHED_PORTS; i++) begin
                case ({enq[i], deq[i]})
                    2'b10: begin
                        if (cnt[i] != PEND_MAX)  // drop when full
                            cnt[i] <= cnt[i] + 1'b1;
                    end
                    2'b01: begin
                        if (cnt[i] != '0)
                            cnt[i] <= cnt[i] - 1'b1;
                    end
                    default: ;  // idle, or enq and deq cancel
                endcase
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SCHED_PORTS; i++)
            req[i] = (cnt[i] != '0);
    end

    // status view of the same mask
    assign pending = req;

endmodule

/* verilog/sched_axil_regs.sv */
// AXI4-Lite register block with ctrl and priority registers and a status readback
`timescale 1ns/1ps

module sched_axil_regs import sched_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  axil_addr_t s_axil_awaddr,
    input  logic       s_axil_awvalid,
    output logic       s_axil_awready,
    input  axil_data_t s_axil_wdata,
    input  logic       s_axil_wvalid,
    output logic       s_axil_wready,
    output logic [1:0] s_axil_bresp,
    output logic       s_axil_bvalid,
    input  logic       s_axil_bready,
    input  axil_addr_t s_axil_araddr,
    input  logic       s_axil_arvalid,
    output logic       s_axil_arready,
    output axil_data_t s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    output logic       s_axil_rvalid,
    input  logic       s_axil_rready,
    input  port_mask_t pending,
    output logic       arb_en,
    output logic       scheme,
    output pri_vec_t   priorities
);

    localparam axil_addr_t ADDR_CTRL   = 4'h0;
    localparam axil_addr_t ADDR_PRI    = 4'h4;
    localparam axil_addr_t ADDR_STATUS = 4'h8;
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    axil_wr_state_t wr_state;
    axil_addr_t     wr_addr;      // AW captured ahead of W
    axil_data_t     wr_data;      // W captured ahead of AW
    axil_addr_t     wr_addr_eff;
    axil_data_t     wr_data_eff;
    axil_data_t     rd_mux;
    logic           aw_hs;
    logic           w_hs;
    logic           ar_hs;
    logic           wr_go;

    assign s_axil_awready = (wr_state == AXW_IDLE) || (wr_state == AXW_ADDR);
    assign s_axil_wready  = (wr_state == AXW_IDLE) || (wr_state == AXW_DATA);
    assign s_axil_bvalid  = (wr_state == AXW_RESP);
    assign s_axil_bresp   = RESP_OKAY;  // writes never fail, unmapped ones are dropped
    assign s_axil_rresp   = RESP_OKAY;

    assign aw_hs = s_axil_awvalid && s_axil_awready;
    assign w_hs  = s_axil_wvalid && s_axil_wready;
    assign ar_hs = s_axil_arvalid && s_axil_arready;

    // both halves present at this edge
    always_comb begin
        case (wr_state)
            AXW_IDLE: wr_go = aw_hs && w_hs;
            AXW_DATA: wr_go = w_hs;
            AXW_ADDR: wr_go = aw_hs;
            default:  wr_go = 1'b0;
        endcase
    end

    assign wr_addr_eff = (wr_state == AXW_DATA) ? wr_addr : s_axil_awaddr;
    assign wr_data_eff = (wr_state == AXW_ADDR) ? wr_data : s_axil_wdata;

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            wr_state <= AXW_IDLE;
        end else begin
            case (wr_state)
                AXW_IDLE: begin
                    if (wr_go)
                        wr_state <= AXW_RESP;
                    else if (aw_hs)
                        wr_state <= AXW_DATA;
                    else if (w_hs)
                        wr_state <= AXW_ADDR;
                end
                AXW_DATA, AXW_ADDR: begin
                    if (wr_go)
                        wr_state <= AXW_RESP;
                end
                AXW_RESP: begin
                    if (s_axil_bready)
                        wr_state <= AXW_IDLE;
                end
                default: wr_state <= AXW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs)
            wr_addr <= s_axil_awaddr;
        if (w_hs)
            wr_data <= s_axil_wdata;
    end

    // register file, status is not writable
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            arb_en     <= 1'b0;
            scheme     <= 1'b0;
            priorities <= '0;
        end else if (wr_go) begin
            case (wr_addr_eff)
                ADDR_CTRL: begin
                    arb_en <= wr_data_eff[0];
                    scheme <= wr_data_eff[1];  // 1 selects WRR
                end
                ADDR_PRI: priorities <= wr_data_eff[$bits(pri_vec_t)-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (s_axil_araddr)
            ADDR_CTRL:   rd_mux = axil_data_t'({scheme, arb_en});
            ADDR_PRI:    rd_mux = axil_data_t'(priorities);
            ADDR_STATUS: rd_mux = axil_data_t'(pending);
            default:     rd_mux = '0;
        endcase
    end

    // one-entry read holding register
    assign s_axil_arready = !s_axil_rvalid;

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n)
            s_axil_rvalid <= 1'b0;
        else if (ar_hs)
            s_axil_rvalid <= 1'b1;
        else if (s_axil_rready)
            s_axil_rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ar_hs)
            s_axil_rdata <= rd_mux;
    end

endmodule

/* verilog/sched_pkg.sv */
// scheduler package with the shared vector types and the AXI write FSM states
`include "sched_cfg.svh"

package sched_pkg;

    localparam int PORT_W = $clog2(`SCHED_PORTS);
    localparam int PRI_W  = $clog2(`SCHED_PRI_LEVELS);
    localparam int PEND_W = $clog2(`SCHED_PEND_MAX + 1);

    typedef logic [PORT_W-1:0]               port_idx_t;  // port number
    typedef logic [`SCHED_PORTS-1:0]         port_mask_t; // one bit per port
    typedef logic [PRI_W-1:0]                pri_t;       // priority or weight
    typedef logic [`SCHED_PORTS*PRI_W-1:0]   pri_vec_t;   // port n at bits 3n+2:3n
    typedef logic [PEND_W-1:0]               pend_cnt_t;

    typedef logic [`SCHED_AXI_ADDR_W-1:0]    axil_addr_t;
    typedef logic [`SCHED_AXI_DATA_W-1:0]    axil_data_t;

    // write channel: DATA waits for W after AW, ADDR waits for AW after W
    typedef enum logic [1:0] {
        AXW_IDLE,
        AXW_DATA,
        AXW_ADDR,
        AXW_RESP
    } axil_wr_state_t;

endpackage

/* verilog/sched_cfg.svh */
// scheduler configuration: port count, priority levels, counter depth, AXI widths
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// input ports feeding the one output port
`define SCHED_PORTS 8

// priority levels in fixed mode, weight levels in WRR mode
`define SCHED_PRI_LEVELS 8

// pending counters saturate here, excess enqueues are lost
`define SCHED_PEND_MAX 15

// host configuration bus
`define SCHED_AXI_ADDR_W 4
`define SCHED_AXI_DATA_W 32

`endif
